// ==== refill_macros.svh ====
// Line geometry and AXI read IDs for the cache refill bridge.
// Included by the package and by any RTL file that sizes ports or constants
// from these values.

`ifndef REFILL_MACROS_SVH
`define REFILL_MACROS_SVH

// words per cache line
`define REFILL_ICACHE_LINE_WORD 8
`define REFILL_DCACHE_LINE_WORD 4

// data word and address width
`define REFILL_WORD_W 32

// arid width on the AXI read address channel
`define REFILL_ID_W 4

// burst ID per requesting cache
`define REFILL_ARID_I 0
`define REFILL_ARID_D 1

`endif

// ==== refill_pkg.sv ====
// Shared types of the cache refill bridge.
// Line types pack word 0 into the low bits, matching the beat order of an
// INCR burst that starts at the aligned line address.

`default_nettype none

`include "refill_macros.svh"

package refill_pkg;

    // one bus word or address
    typedef logic [`REFILL_WORD_W-1:0] word_t;

    // full cache lines, word 0 in the low bits
    typedef logic [`REFILL_ICACHE_LINE_WORD*`REFILL_WORD_W-1:0] iline_t;
    typedef logic [`REFILL_DCACHE_LINE_WORD*`REFILL_WORD_W-1:0] dline_t;

    // owner of the burst in flight
    typedef enum logic {
        SRC_I = 1'b0,  // instruction cache
        SRC_D = 1'b1   // data cache
    } refill_src_e;

    // word slot inside a line, sized for the longer line
    typedef logic [$clog2(`REFILL_ICACHE_LINE_WORD)-1:0] beat_idx_t;

endpackage

`default_nettype wire

// ==== refill_ctrl_if.sv ====
// Steering bundle from the refill FSM to the beat counter and line buffers.
// The FSM marks burst start, each accepted beat and the final beat per source;
// the counter returns the word slot of the current beat.

`timescale 1ns/1ns
`default_nettype none

interface refill_ctrl_if;
    import refill_pkg::*;

    logic      burst_start;  // address accepted
    logic      beat_take;    // rvalid and rready together
    beat_idx_t beat;         // slot of the current beat
    logic      line_end_i;   // final beat of an icache line
    logic      line_end_d;   // final beat of a dcache line

    modport fsm (
        output burst_start,
        output beat_take,
        output line_end_i,
        output line_end_d,
        input  beat
    );

    modport counter (
        input  burst_start,
        input  beat_take,
        output beat
    );

    modport buffer (
        input  beat_take,
        input  beat
    );

endinterface

`default_nettype wire

// ==== refill_fsm.sv ====
// Arbitration and AXI read burst control for the cache refill bridge.
// Picks one requester (dcache wins a tie), issues one INCR burst of a full line,
// accepts beats until the last one and pulses the done strobe of the owner.
// One burst is in flight at a time.

`timescale 1ns/1ns
`default_nettype none

`include "refill_macros.svh"

module refill_fsm (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic                    i_req,
    input  logic                    d_req,
    input  refill_pkg::word_t       i_addr,
    input  refill_pkg::word_t       d_addr,
    input  logic                    arready,
    input  logic                    rvalid,
    input  logic                    rlast,
    output logic                    arvalid,
    output logic                    rready,
    output refill_pkg::word_t       araddr,
    output logic [3:0]              arlen,
    output logic [`REFILL_ID_W-1:0] arid,
    output logic                    take_i,
    output logic                    take_d,
    output logic                    i_done,
    output logic                    d_done,
    refill_ctrl_if.fsm              ctrl
);
    import refill_pkg::*;

    localparam int WORD_BYTES = `REFILL_WORD_W / 8;
    localparam int I_OFF = $clog2(`REFILL_ICACHE_LINE_WORD * WORD_BYTES);  // 32 bytes
    localparam int D_OFF = $clog2(`REFILL_DCACHE_LINE_WORD * WORD_BYTES);  // 16 bytes
    localparam logic [3:0] I_LEN = 4'(`REFILL_ICACHE_LINE_WORD - 1);
    localparam logic [3:0] D_LEN = 4'(`REFILL_DCACHE_LINE_WORD - 1);
    localparam logic [`REFILL_ID_W-1:0] I_ID = `REFILL_ARID_I;
    localparam logic [`REFILL_ID_W-1:0] D_ID = `REFILL_ARID_D;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        DONE
    } state_t;

    state_t      state;
    state_t      state_nxt;
    refill_src_e src;        // owner of the burst
    logic        last_beat;

    assign arvalid = (state == ADDR);
    assign rready  = (state == DATA);

    assign ctrl.burst_start = arvalid & arready;
    assign ctrl.beat_take   = rvalid & rready;

    // close on rlast, or once the final slot of the line is filled
    assign last_beat = ctrl.beat_take & (rlast | (ctrl.beat == beat_idx_t'(arlen)));

    assign ctrl.line_end_i = last_beat & (src == SRC_I);
    assign ctrl.line_end_d = last_beat & (src == SRC_D);

    // per-buffer write strobes
    assign take_i = ctrl.beat_take & (src == SRC_I);
    assign take_d = ctrl.beat_take & (src == SRC_D);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_req | d_req) begin
                    state_nxt = ADDR;
                end
            end
            ADDR: begin
                if (arready) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (last_beat) begin
                    state_nxt = DONE;
                end
            end
            default: begin
                state_nxt = IDLE;  // DONE lasts one cycle
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state  <= IDLE;
            src    <= SRC_I;
            i_done <= 1'b0;
            d_done <= 1'b0;
        end else begin
            state  <= state_nxt;
            i_done <= ctrl.line_end_i;  // one cycle after the last beat
            d_done <= ctrl.line_end_d;
            if (state == IDLE) begin
                if (d_req) begin
                    src <= SRC_D;
                end else if (i_req) begin
                    src <= SRC_I;
                end
            end
        end
    end

    // address phase payload, held stable while arvalid is up
    always_ff @(posedge aclk) begin
        if (state == IDLE) begin
            if (d_req) begin
                araddr <= {d_addr[`REFILL_WORD_W-1:D_OFF], {D_OFF{1'b0}}};
                arlen  <= D_LEN;
                arid   <= D_ID;
            end else if (i_req) begin
                araddr <= {i_addr[`REFILL_WORD_W-1:I_OFF], {I_OFF{1'b0}}};
                arlen  <= I_LEN;
                arid   <= I_ID;
            end
        end
    end

endmodule

`default_nettype wire

// ==== beat_counter.sv ====
// Word slot counter for the read burst in flight.
// Restarts at slot 0 when the address is accepted and steps once per beat,
// so the line buffers take their write position from here.

`timescale 1ns/1ns
`default_nettype none

module beat_counter (
    input  logic           aclk,
    input  logic           reset,
    refill_ctrl_if.counter ctrl
);

    always_ff @(posedge aclk) begin
        if (reset) begin
            ctrl.beat <= '0;
        end else if (ctrl.burst_start) begin
            ctrl.beat <= '0;  // new burst starts at word 0
        end else if (ctrl.beat_take) begin
            ctrl.beat <= ctrl.beat + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== line_buffer.sv ====
// Collects the read beats of one cache line and holds the assembled line.
// The line type and word count are parameters so one block serves both caches.
// The line stays valid until the next burst for the same cache writes into it.

`timescale 1ns/1ns
`default_nettype none

module line_buffer #(
    parameter type line_t = refill_pkg::iline_t,
    parameter int  WORDS  = 8
) (
    input  logic              aclk,
    input  logic              reset,
    input  logic              take,
    input  refill_pkg::word_t rdata,
    refill_ctrl_if.buffer     ctrl,
    output line_t             line
);
    import refill_pkg::*;

    localparam int WORD_W = $bits(word_t);
    localparam int IDX_W  = $clog2(WORDS);

    logic [IDX_W-1:0] slot;

    // shorter lines use only the low bits of the shared index
    assign slot = ctrl.beat[IDX_W-1:0];

    always_ff @(posedge aclk) begin
        if (reset) begin
            line <= '0;
        end else if (take) begin
            line[slot*WORD_W +: WORD_W] <= rdata;  // word lands at its own beat
        end
    end

endmodule

`default_nettype wire

// ==== axi_refill_bridge.sv ====
// Top level of the cache refill bridge on the AXI read channel.
// Each cache holds req with a word address until its done pulse; the refilled
// line is on i_line or d_line from that pulse on. Slave is assumed to serve
// 4-byte INCR bursts with OKAY responses.

`timescale 1ns/1ns
`default_nettype none

`include "refill_macros.svh"

module axi_refill_bridge (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic                    i_req,
    input  logic                    d_req,
    input  refill_pkg::word_t       i_addr,
    input  refill_pkg::word_t       d_addr,
    output logic                    i_done,
    output logic                    d_done,
    output refill_pkg::iline_t      i_line,
    output refill_pkg::dline_t      d_line,
    output logic [`REFILL_ID_W-1:0] arid,
    output refill_pkg::word_t       araddr,
    output logic [3:0]              arlen,
    output logic                    arvalid,
    input  logic                    arready,
    input  refill_pkg::word_t       rdata,
    input  logic                    rlast,
    input  logic                    rvalid,
    output logic                    rready
);
    import refill_pkg::*;

    logic take_i;  // beat belongs to the icache line
    logic take_d;  // beat belongs to the dcache line

    refill_ctrl_if ctrl_i ();

    refill_fsm fsm_i (
        .aclk    (aclk),
        .reset   (reset),
        .i_req   (i_req),
        .d_req   (d_req),
        .i_addr  (i_addr),
        .d_addr  (d_addr),
        .arready (arready),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .arvalid (arvalid),
        .rready  (rready),
        .araddr  (araddr),
        .arlen   (arlen),
        .arid    (arid),
        .take_i  (take_i),
        .take_d  (take_d),
        .i_done  (i_done),
        .d_done  (d_done),
        .ctrl    (ctrl_i.fsm)
    );

    beat_counter cnt_i (
        .aclk  (aclk),
        .reset (reset),
        .ctrl  (ctrl_i.counter)
    );

    // instruction line, eight words
    line_buffer #(
        .line_t (iline_t),
        .WORDS  (`REFILL_ICACHE_LINE_WORD)
    ) ibuf_i (
        .aclk  (aclk),
        .reset (reset),
        .take  (take_i),
        .rdata (rdata),
        .ctrl  (ctrl_i.buffer),
        .line  (i_line)
    );

    // data line, four words
    line_buffer #(
        .line_t (dline_t),
        .WORDS  (`REFILL_DCACHE_LINE_WORD)
    ) dbuf_i (
        .aclk  (aclk),
        .reset (reset),
        .take  (take_d),
        .rdata (rdata),
        .ctrl  (ctrl_i.buffer),
        .line  (d_line)
    );

endmodule

`default_nettype wire

// ==== tb_axi_refill.sv ====
// Testbench for the AXI cache refill bridge.
// Reads requests and expected burst fields from refill_trace.txt, plays the
// AXI read slave with a fixed memory pattern and checks bursts, done pulses
// and the refilled lines. Stops at the first mismatch or timeout.

`timescale 1ns/1ns
`default_nettype none

`include "refill_macros.svh"

module tb_axi_refill;
    import refill_pkg::*;

    localparam int    WAIT_LIMIT = 200;            // cycles per wait
    localparam word_t MEM_XOR    = 32'h5A5A0000;   // slave data pattern
    localparam int    WORD_BITS  = $bits(word_t);

    logic                    aclk;
    logic                    reset;
    logic                    i_req;
    logic                    d_req;
    word_t                   i_addr;
    word_t                   d_addr;
    logic                    i_done;
    logic                    d_done;
    iline_t                  i_line;
    dline_t                  d_line;
    logic [`REFILL_ID_W-1:0] arid;
    word_t                   araddr;
    logic [3:0]              arlen;
    logic                    arvalid;
    logic                    arready;
    word_t                   rdata;
    logic                    rlast;
    logic                    rvalid;
    logic                    rready;

    integer seed;
    iline_t exp_iline;  // model of the instruction line
    dline_t exp_dline;  // model of the data line

    axi_refill_bridge dut_i (
        .aclk    (aclk),
        .reset   (reset),
        .i_req   (i_req),
        .d_req   (d_req),
        .i_addr  (i_addr),
        .d_addr  (d_addr),
        .i_done  (i_done),
        .d_done  (d_done),
        .i_line  (i_line),
        .d_line  (d_line),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_iline(input string name, input iline_t actual, input iline_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_dline(input string name, input dline_t actual, input dline_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // arlen and arid
    task automatic check_nibble(input string name, input logic [3:0] actual,
                                input logic [3:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // outputs are read and inputs driven shortly after the rising edge
    task automatic next_cycle();
        @(posedge aclk);
        #2;
    endtask

    function automatic word_t pattern_word(input word_t byte_addr);
        return byte_addr ^ MEM_XOR;
    endfunction

    function automatic iline_t build_iline(input word_t base);
        iline_t acc;
        int     k;
        acc = '0;
        for (k = 0; k < $bits(iline_t) / WORD_BITS; k++) begin
            acc[k*WORD_BITS +: WORD_BITS] = pattern_word(base + word_t'(4 * k));
        end
        return acc;
    endfunction

    function automatic dline_t build_dline(input word_t base);
        dline_t acc;
        int     k;
        acc = '0;
        for (k = 0; k < $bits(dline_t) / WORD_BITS; k++) begin
            acc[k*WORD_BITS +: WORD_BITS] = pattern_word(base + word_t'(4 * k));
        end
        return acc;
    endfunction

    // rready held, no address and no done while beats are pending
    task automatic check_data_phase();
        check_bit("rready", rready, 1'b1);
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("i_done", i_done, 1'b0);
        check_bit("d_done", d_done, 1'b0);
    endtask

    task automatic wait_arvalid();
        int n;
        n = 0;
        while (arvalid !== 1'b1) begin
            if (n >= WAIT_LIMIT) begin
                $display("timeout: arvalid never rose within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
            next_cycle();
            n++;
        end
    endtask

    // slave side of one burst, entered with arvalid already high
    task automatic serve_burst(input word_t addr, input logic [3:0] len,
                               input logic [3:0] id, input int delay, input bit is_d);
        int c;
        int k;
        int gap;
        check_word("araddr", araddr, addr);
        check_nibble("arlen", arlen, len);
        check_nibble("arid", arid, id);
        for (c = 0; c < delay; c++) begin
            next_cycle();
            check_bit("arvalid", arvalid, 1'b1);  // held until arready
            check_word("araddr", araddr, addr);
            check_nibble("arlen", arlen, len);
            check_nibble("arid", arid, id);
        end
        arready = 1'b1;
        next_cycle();
        arready = 1'b0;
        check_data_phase();
        for (k = 0; k <= int'(len); k++) begin
            gap = $unsigned($random(seed)) % 3;
            for (c = 0; c < gap; c++) begin
                next_cycle();
                check_data_phase();
            end
            rvalid = 1'b1;
            rdata  = pattern_word(addr + word_t'(4 * k));
            rlast  = (k == int'(len));
            next_cycle();
            rvalid = 1'b0;
            rlast  = 1'b0;
            if (k < int'(len)) begin
                check_data_phase();
            end
        end
        // one cycle after the rlast beat
        check_bit("rready", rready, 1'b0);  // dropped after the rlast beat
        check_bit("arvalid", arvalid, 1'b0);
        if (is_d) begin
            exp_dline = build_dline(addr);
            check_bit("d_done", d_done, 1'b1);
            check_bit("i_done", i_done, 1'b0);
            d_req = 1'b0;
        end else begin
            exp_iline = build_iline(addr);
            check_bit("i_done", i_done, 1'b1);
            check_bit("d_done", d_done, 1'b0);
            i_req = 1'b0;
        end
        check_iline("i_line", i_line, exp_iline);
        check_dline("d_line", d_line, exp_dline);
        next_cycle();
        check_bit("i_done", i_done, 1'b0);  // single cycle pulse
        check_bit("d_done", d_done, 1'b0);
    endtask

    task automatic run_entry(input logic [7:0] src, input word_t ia, input word_t da,
                             input int delay, input word_t a0, input logic [3:0] l0,
                             input logic [3:0] id0, input word_t a1, input logic [3:0] l1,
                             input logic [3:0] id1);
        check_bit("arvalid", arvalid, 1'b0);
        if (src == "I" || src == "B") begin
            i_req  = 1'b1;
            i_addr = ia;
        end
        if (src == "D" || src == "B") begin
            d_req  = 1'b1;
            d_addr = da;
        end
        next_cycle();
        check_bit("arvalid", arvalid, 1'b1);  // one cycle after the request
        serve_burst(a0, l0, id0, delay, src != "I");
        if (src == "B") begin
            wait_arvalid();  // instruction burst after d_done
            serve_burst(a1, l1, id1, delay, 1'b0);
        end
    endtask

    initial begin
        int         fd;
        int         rc;
        int         entries;
        string      text;
        logic [7:0] src;
        word_t      ia;
        word_t      da;
        int         delay;
        word_t      a0;
        word_t      a1;
        logic [3:0] l0;
        logic [3:0] l1;
        logic [3:0] id0;
        logic [3:0] id1;

        seed    = 32'h83968b35;
        entries = 0;
        reset   = 1'b1;
        i_req   = 1'b0;
        d_req   = 1'b0;
        i_addr  = '0;
        d_addr  = '0;
        arready = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        rvalid  = 1'b0;
        repeat (2) @(posedge aclk);
        #2;
        reset = 1'b0;

        exp_iline = '0;
        exp_dline = '0;
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("rready", rready, 1'b0);
        check_bit("i_done", i_done, 1'b0);
        check_bit("d_done", d_done, 1'b0);
        check_iline("i_line", i_line, exp_iline);
        check_dline("d_line", d_line, exp_dline);

        fd = $fopen("refill_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file refill_trace.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            text = "";
            rc = $fgets(text, fd);
            if (rc == 0 || text.len() < 2 || text.getc(0) == "#") begin
                continue;  // blank or column notes
            end
            rc = $sscanf(text, "%c %h %h %d %h %h %h %h %h %h",
                         src, ia, da, delay, a0, l0, id0, a1, l1, id1);
            if (rc != 10) begin
                $display("malformed trace line: %s", text);
                abort_run();
            end
            run_entry(src, ia, da, delay, a0, l0, id0, a1, l1, id1);
            entries++;
        end
        $fclose(fd);

        if (entries == 0) begin
            $display("the trace file held no requests");
            abort_run();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== refill_trace.txt ====
# src(I/D/B) i_addr d_addr ar_delay | araddr arlen arid of burst 1 | same for burst 2
# hex except ar_delay; burst 2 is used only for B, where the data burst comes first
I 00001234 00000000 0 00001220 7 0 00000000 0 0
D 00000000 0000a5c8 1 0000a5c0 3 1 00000000 0 0
B 00400084 1000003c 2 10000030 3 1 00400080 7 0
I 7ffffffc 00000000 6 7fffffe0 7 0 00000000 0 0
D 00000000 deadbeef 5 deadbee0 3 1 00000000 0 0
B 0000001f fffffff4 4 fffffff0 3 1 00000000 7 0
I 12345678 00000000 3 12345660 7 0 00000000 0 0
D 00000000 00000000 0 00000000 3 1 00000000 0 0
I 00000020 00000000 9 00000020 7 0 00000000 0 0
D 00000000 8000000c 7 80000000 3 1 00000000 0 0
B 00000ff8 00000ffc 0 00000ff0 3 1 00000fe0 7 0

// ==== filelist.f ====
+incdir+.
refill_pkg.sv
refill_ctrl_if.sv
refill_fsm.sv
beat_counter.sv
line_buffer.sv
axi_refill_bridge.sv
tb_axi_refill.sv

// ==== Makefile ====
# Verilator build and run of the refill bridge testbench
VERILATOR ?= verilator
TOP       ?= tb_axi_refill
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
